// File: test/tcdm_tests.txt
# test op(W/R) addr wdata be id exp, all hex after op
# exp is the read data, ignored on writes
w_full   W 0010 cafef00d f 1 00000000
r_full   R 0010 00000000 0 2 cafef00d
w_bytes  W 0010 000055aa 5 3 00000000
r_bytes  R 0010 00000000 0 4 ca00f0aa
r_fresh  R 0100 00000000 0 5 ffffffff
w_bank0  W 0020 11111111 f 6 00000000
w_bank1  W 0024 22222222 f 7 00000000
w_bank2  W 0028 33333333 f 8 00000000
w_bank3  W 002c 44444444 f 9 00000000
r_bank2  R 0028 00000000 0 a 33333333
r_bank0  R 0020 00000000 0 b 11111111
r_alias  R 0424 00000000 0 c 22222222
w_alias  W 082c 55667788 3 d 00000000
r_bank3  R 002c 00000000 0 e 44447788
r_bank1  R 0024 00000000 0 f 22222222
r_again  R 0010 00000000 0 0 ca00f0aa
r_high   R fc2c 00000000 0 1 44447788
r_fresh2 R 03fc 00000000 0 2 ffffffff

// File: project.f
+incdir+design
design/tcdm_req_pkg.sv
design/tcdm_mem_pkg.sv
design/tcdm_intf.sv
design/tcdm_cmd_fifo.sv
design/tcdm_port_ctrl.sv
design/tcdm_banks_wrap.sv
design/tcdm_subsys.sv
test/tcdm_subsys_properties.sv
test/tcdm_subsys_tb.sv

// File: Makefile
# Verilator flow for the TCDM subsystem; every variable can be overridden on the command line
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tcdm_subsys_tb
RTL_TOP   ?= tcdm_subsys
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SRCS      := $(shell grep -v '^+' $(FILELIST)) design/tcdm_config.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TB_TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TB_TOP)
	$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tcdm_subsys_tb.sv
// data file driven testbench for tcdm_subsys, reference memory model and random back-pressure
`timescale 1ns/1ns
`default_nettype none

module tcdm_subsys_tb;
  localparam int MaxTests = 64;

  logic        clk_i = 1'b0;
  logic        rst_ni, cmd_valid_i, cmd_ready_o, cmd_we_i;
  logic [15:0] cmd_addr_i;
  logic [31:0] cmd_wdata_i, resp_rdata_o;
  logic [3:0]  cmd_be_i, cmd_id_i, resp_id_o;
  logic        resp_valid_o, resp_ready_i;

  // one entry per test, {we, addr, wdata, be, id} in port order
  logic [56:0]  t_cmd   [MaxTests];
  logic [127:0] t_name  [MaxTests];
  logic [31:0]  t_exp   [MaxTests];   // read data per the model
  logic [31:0]  ref_mem [256];        // word index addr[9:2], wraps at 1 KiB
  int           exp_q [$];            // accepted reads, oldest first
  int           n_tests = 0, n_reads = 0, n_resp = 0, cycle_cnt = 0, limit = 0;
  int           mismatch_cnt = 0, fail_cnt = 0;
  logic [15:0]  lfsr_q = 16'd22587;

  always #4 clk_i = ~clk_i;   // 8 ns period

  tcdm_subsys i_tcdm_subsys (.*);

  // fibonacci, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // read the table, replay writes on the model, keep each read's expected word
  task automatic load_tests();
    int               fd;
    logic [8*128-1:0] line;
    logic [127:0]     name;
    logic [7:0]       op;
    logic [15:0]      addr;
    logic [31:0]      wdata, file_exp;
    logic [3:0]       be, id;
    foreach (ref_mem[w]) begin
      ref_mem[w] = '1;   // banks power up all ones
    end
    fd = $fopen("test/tcdm_tests.txt", "r");
    while (fd != 0 && !$feof(fd) && n_tests < MaxTests) begin
      line = '0;
      void'($fgets(line, fd));
      if ($sscanf(line, "%s %s %h %h %h %h %h",
                  name, op, addr, wdata, be, id, file_exp) == 7) begin   // comments fall short
        t_name[n_tests] = name;
        t_cmd[n_tests]  = {op == "W", addr, wdata, be, id};
        for (int k = 0; k < 4; k++) begin
          if (op == "W" && be[k]) ref_mem[addr[9:2]][k*8 +: 8] = wdata[k*8 +: 8];
        end
        if (op != "W") begin
          t_exp[n_tests] = ref_mem[addr[9:2]];
          n_reads++;
          if (file_exp !== t_exp[n_tests]) begin   // table and model must agree
            $display("test %0s: table data %h differs from the memory model %h",
                     name, file_exp, t_exp[n_tests]);
            fail_cnt++;
          end
        end
        n_tests++;
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  // one command per iteration, sometimes after an idle cycle
  task automatic drive_cmds();
    for (int i = 0; i < n_tests; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      if (lfsr_q[0]) begin
        @(posedge clk_i);   // gap on cmd_valid_i
        #1;
      end
      cmd_valid_i = 1'b1;
      {cmd_we_i, cmd_addr_i, cmd_wdata_i, cmd_be_i, cmd_id_i} = t_cmd[i];
      @(negedge clk_i);
      while (!cmd_ready_o) @(negedge clk_i);   // held until the fifo has room
      if (!t_cmd[i][56]) exp_q.push_back(i);   // read taken at the coming edge
      @(posedge clk_i);
      #1;
      cmd_valid_i = 1'b0;
    end
  endtask

  // random resp_ready_i, responses checked in command order at the falling edge
  initial begin : check_resp
    int idx;
    @(posedge rst_ni);
    forever begin
      @(posedge clk_i);
      #2;
      lfsr_q = lfsr_step(lfsr_q);
      resp_ready_i = lfsr_q[0];
      @(negedge clk_i);
      if (resp_valid_o && exp_q.size() == 0) begin   // lost order or duplicate
        $display("response with no read outstanding at cycle %0d", cycle_cnt);
        fail_cnt++;
      end else if (resp_valid_o && resp_ready_i) begin
        idx = exp_q.pop_front();
        n_resp++;
        if (resp_rdata_o !== t_exp[idx] || resp_id_o !== t_cmd[idx][3:0]) begin
          mismatch_cnt++;
          $display("MISMATCH %0s expected %h id %h actual %h id %h", t_name[idx],
                   t_exp[idx], t_cmd[idx][3:0], resp_rdata_o, resp_id_o);
        end
      end
    end
  end

  initial begin : main
    {rst_ni, cmd_valid_i, cmd_we_i, cmd_addr_i, cmd_wdata_i, cmd_be_i, cmd_id_i} = '0;
    resp_ready_i = 1'b0;
    load_tests();
    limit = 40 * n_tests;
    if (n_tests == 0) begin
      $display("no tests read from test/tcdm_tests.txt");
      fail_cnt++;
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (resp_valid_o !== 1'b0 || cmd_ready_o !== 1'b1) begin
      $display("after reset resp_valid_o is %b, cmd_ready_o is %b", resp_valid_o, cmd_ready_o);
      fail_cnt++;
    end
    @(posedge clk_i);
    #1;
    drive_cmds();
    wait (n_resp == n_reads);
    repeat (10) @(posedge clk_i);   // room for a stray extra response
    $display("%0d tests, %0d of %0d reads answered, %0d mismatches, %0d other errors",
             n_tests, n_resp, n_reads, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // limit scales with the table length
  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (limit > 0 && cycle_cnt > limit) begin
      $display("timeout after %0d cycles, %0d of %0d reads answered", cycle_cnt, n_resp, n_reads);
      $display("Simulation FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/tcdm_subsys_properties.sv
// handshake and bank request assertions, attached to every tcdm_subsys by the bind below
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_config.svh"

module tcdm_subsys_properties (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      resp_valid_o,
  input logic                      resp_ready_i,
  input tcdm_req_pkg::data_t       resp_rdata_o,
  input tcdm_req_pkg::id_t         resp_id_o,
  input logic [`TCDM_NB_BANKS-1:0] bank_req   // one bit per bank
);

  // a stalled response keeps valid, data and id
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=>
      resp_valid_o && $stable(resp_rdata_o) && $stable(resp_id_o))
    else $error("response changed before the handshake");

  a_resp_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !resp_valid_o)
    else $error("resp_valid_o high during reset");

  // controller addresses a single bank per request
  a_req_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_req))
    else $error("more than one bank req high");

endmodule

bind tcdm_subsys tcdm_subsys_properties i_properties (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .resp_valid_o (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_rdata_o (resp_rdata_o),
  .resp_id_o    (resp_id_o),
  .bank_req     ({bank_if[3].req, bank_if[2].req, bank_if[1].req, bank_if[0].req})
);

`default_nettype wire

// File: design/tcdm_subsys.sv
// tcdm top level with plain valid/ready ports, ties fifo, controller and banks together
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_config.svh"

module tcdm_subsys (
  input  logic                clk_i,
  input  logic                rst_ni,
  // command channel
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  input  logic                cmd_we_i,
  input  tcdm_req_pkg::addr_t cmd_addr_i,
  input  tcdm_req_pkg::data_t cmd_wdata_i,
  input  tcdm_req_pkg::be_t   cmd_be_i,
  input  tcdm_req_pkg::id_t   cmd_id_i,
  // response channel, reads only
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output tcdm_req_pkg::data_t resp_rdata_o,
  output tcdm_req_pkg::id_t   resp_id_o
);

  tcdm_cmd_if  cmd_if ();                        // fifo head to controller
  tcdm_bank_if bank_if [`TCDM_NB_BANKS] ();      // one per bank

  tcdm_cmd_fifo #(
    .Depth (`TCDM_FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_we_i    (cmd_we_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_be_i    (cmd_be_i),
    .cmd_id_i    (cmd_id_i),
    .head        (cmd_if)
  );

  tcdm_port_ctrl i_port_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd          (cmd_if),
    .bank         (bank_if),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_id_o    (resp_id_o)
  );

  tcdm_banks_wrap #(
    .NbBanks   (`TCDM_NB_BANKS),
    .BankWords (`TCDM_BANK_WORDS)
  ) i_banks_wrap (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tcdm_target (bank_if)
  );

endmodule

`default_nettype wire

// File: design/tcdm_banks_wrap.sv
// array of word interleaved sram banks with grant, read valid and id echo per bank
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_config.svh"

module tcdm_banks_wrap #(
  parameter int unsigned NbBanks   = `TCDM_NB_BANKS,
  parameter int unsigned BankWords = `TCDM_BANK_WORDS
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  tcdm_bank_if.target tcdm_target [NbBanks]
);
  import tcdm_req_pkg::*;

  localparam int unsigned NbBytes = $bits(be_t);

  for (genvar b = 0; b < NbBanks; b++) begin : gen_banks
    // simulation start value is all ones, not touched by reset
    data_t mem_q [BankWords] = '{default: '1};
    data_t rdata_q;
    id_t   rid_q;
    logic  rvalid_q;
    logic  take;   // granted request this edge

    assign tcdm_target[b].gnt = 1'b1;   // always ready
    assign take               = tcdm_target[b].req && tcdm_target[b].gnt;

    // single port sram, write or read per cycle
    always_ff @(posedge clk_i) begin : proc_sram
      if (take) begin
        if (tcdm_target[b].we) begin
          for (int k = 0; k < NbBytes; k++) begin
            if (tcdm_target[b].be[k]) begin
              mem_q[tcdm_target[b].row][k*8 +: 8] <= tcdm_target[b].wdata[k*8 +: 8];
            end
          end
        end else begin
          rdata_q <= mem_q[tcdm_target[b].row];   // registered read
        end
      end
    end

    // read valid only for reads
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rvalid
      if (!rst_ni) begin
        rvalid_q <= 1'b0;
      end else begin
        rvalid_q <= take && !tcdm_target[b].we;
      end
    end

    // id echo, lines up with r_valid
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rid
      if (!rst_ni) begin
        rid_q <= '0;
      end else if (take) begin
        rid_q <= tcdm_target[b].id;
      end
    end

    assign tcdm_target[b].r_valid = rvalid_q;
    assign tcdm_target[b].r_data  = rdata_q;
    assign tcdm_target[b].r_id    = rid_q;
  end

endmodule

`default_nettype wire

// File: design/tcdm_port_ctrl.sv
// port controller that pops commands, issues bank requests and holds read responses
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_config.svh"

module tcdm_port_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  tcdm_cmd_if.sink            cmd,
  tcdm_bank_if.initiator      bank [`TCDM_NB_BANKS],
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output tcdm_req_pkg::data_t resp_rdata_o,
  output tcdm_req_pkg::id_t   resp_id_o
);
  import tcdm_req_pkg::*;
  import tcdm_mem_pkg::*;

  localparam int unsigned NbBanks = `TCDM_NB_BANKS;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // registered request, broadcast except for req
  logic      req_q;
  bank_sel_t sel_q;
  row_t      row_q;
  logic      we_q;
  data_t     wdata_q;
  be_t       be_q;
  id_t       id_q;

  // read returns gathered from all banks
  logic [NbBanks-1:0] r_valid_vec;
  data_t              r_data_arr [NbBanks];
  id_t                r_id_arr   [NbBanks];

  logic  pop;
  logic  r_hit;     // selected bank returns data
  logic  resp_hs;
  logic  resp_valid_q;
  data_t resp_rdata_q;
  id_t   resp_id_q;

  assign cmd.ready = (state_q == IDLE);
  assign pop       = cmd.valid && cmd.ready;
  assign r_hit     = (state_q == HOLD_RESP) && r_valid_vec[sel_q];
  assign resp_hs   = resp_valid_q && resp_ready_i;

  for (genvar i = 0; i < NbBanks; i++) begin : gen_bank_port
    assign bank[i].req   = req_q && (sel_q == bank_sel_t'(i));   // one-hot req
    assign bank[i].we    = we_q;
    assign bank[i].row   = row_q;
    assign bank[i].wdata = wdata_q;
    assign bank[i].be    = be_q;
    assign bank[i].id    = id_q;
    assign r_valid_vec[i] = bank[i].r_valid;
    assign r_data_arr[i]  = bank[i].r_data;
    assign r_id_arr[i]    = bank[i].r_id;
  end

  always_comb begin : proc_next_state
    state_d = state_q;
    case (state_q)
      IDLE:      if (pop && !cmd.we) state_d = HOLD_RESP;   // writes stay here
      HOLD_RESP: if (resp_hs) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl
    if (!rst_ni) begin
      state_q      <= IDLE;
      req_q        <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= pop;   // single cycle pulse
      if (r_hit) begin
        resp_valid_q <= 1'b1;
      end else if (resp_hs) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  // decode on pop, addr bits above the row wrap
  always_ff @(posedge clk_i) begin : proc_req_payload
    if (pop) begin
      sel_q   <= cmd.addr[BankLsb +: $bits(bank_sel_t)];
      row_q   <= cmd.addr[RowLsb +: $bits(row_t)];
      we_q    <= cmd.we;
      wdata_q <= cmd.wdata;
      be_q    <= cmd.be;
      id_q    <= cmd.id;
    end
  end

  always_ff @(posedge clk_i) begin : proc_resp_payload
    if (r_hit) begin
      resp_rdata_q <= r_data_arr[sel_q];
      resp_id_q    <= r_id_arr[sel_q];
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_rdata_o = resp_rdata_q;
  assign resp_id_o    = resp_id_q;

endmodule

`default_nettype wire

// File: design/tcdm_cmd_fifo.sv
// circular command buffer between the top level command port and the port controller
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_config.svh"

module tcdm_cmd_fifo #(
  parameter int unsigned Depth = `TCDM_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  input  logic                cmd_we_i,
  input  tcdm_req_pkg::addr_t cmd_addr_i,
  input  tcdm_req_pkg::data_t cmd_wdata_i,
  input  tcdm_req_pkg::be_t   cmd_be_i,
  input  tcdm_req_pkg::id_t   cmd_id_i,
  tcdm_cmd_if.source          head
);
  import tcdm_req_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  // command payload per entry
  logic  we_mem    [Depth];
  addr_t addr_mem  [Depth];
  data_t wdata_mem [Depth];
  be_t   be_mem    [Depth];
  id_t   id_mem    [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;   // entries held
  logic            full;
  logic            push;
  logic            pop;

  assign full        = (count_q == CntW'(Depth));
  assign pop         = head.valid && head.ready;
  assign cmd_ready_o = !full || head.ready;   // full still takes a push when popping
  assign push        = cmd_valid_i && cmd_ready_o;

  // head of queue straight from storage
  assign head.valid = (count_q != '0);
  assign head.we    = we_mem[rd_ptr_q];
  assign head.addr  = addr_mem[rd_ptr_q];
  assign head.wdata = wdata_mem[rd_ptr_q];
  assign head.be    = be_mem[rd_ptr_q];
  assign head.id    = id_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin : proc_store
    if (push) begin
      we_mem[wr_ptr_q]    <= cmd_we_i;
      addr_mem[wr_ptr_q]  <= cmd_addr_i;
      wdata_mem[wr_ptr_q] <= cmd_wdata_i;
      be_mem[wr_ptr_q]    <= cmd_be_i;
      id_mem[wr_ptr_q]    <= cmd_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptrs
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;   // wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/tcdm_intf.sv
// command and per bank request interfaces used between fifo, controller and banks
`timescale 1ns/1ns
`default_nettype none

// valid/ready command channel from fifo head to controller
interface tcdm_cmd_if;
  import tcdm_req_pkg::*;

  logic  valid;
  logic  ready;
  logic  we;     // 1 = write
  addr_t addr;
  data_t wdata;
  be_t   be;
  id_t   id;

  modport source (output valid, we, addr, wdata, be, id, input ready);
  modport sink   (input valid, we, addr, wdata, be, id, output ready);

endinterface

// single bank port, grant and read return in the style of the bank wrapper
interface tcdm_bank_if;
  import tcdm_req_pkg::*;
  import tcdm_mem_pkg::*;

  logic  req;
  logic  gnt;       // tied high by the bank
  logic  we;
  row_t  row;       // already decoded word index
  data_t wdata;
  be_t   be;
  id_t   id;
  logic  r_valid;   // one cycle after a granted read
  data_t r_data;
  id_t   r_id;      // echo of id

  modport initiator (
    output req, we, row, wdata, be, id,
    input  gnt, r_valid, r_data, r_id
  );

  modport target (
    input  req, we, row, wdata, be, id,
    output gnt, r_valid, r_data, r_id
  );

endinterface

`default_nettype wire

// File: design/tcdm_mem_pkg.sv
// storage side types for bank decode and controller state, import in the controller and banks
`default_nettype none

`include "tcdm_config.svh"

package tcdm_mem_pkg;

  // word interleaving sits right above the byte offset
  localparam int unsigned BankLsb = $clog2(`TCDM_DATA_W / 8);
  localparam int unsigned RowLsb  = BankLsb + $clog2(`TCDM_NB_BANKS);

  // which bank, addr[3:2] by default
  typedef logic [$clog2(`TCDM_NB_BANKS)-1:0] bank_sel_t;

  // word within a bank, addr[9:4] by default
  typedef logic [$clog2(`TCDM_BANK_WORDS)-1:0] row_t;

  // one read in flight at most
  typedef enum logic {
    IDLE,       // free to pop the next command
    HOLD_RESP   // read issued, waiting for data or handshake
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/tcdm_req_pkg.sv
// request side vector types shared by the command path, import where fields are handled
`default_nettype none

`include "tcdm_config.svh"

package tcdm_req_pkg;

  // byte address as seen on the command port
  typedef logic [`TCDM_ADDR_W-1:0] addr_t;

  // one data word
  typedef logic [`TCDM_DATA_W-1:0] data_t;

  // one enable per byte lane
  typedef logic [`TCDM_DATA_W/8-1:0] be_t;

  // transaction tag, echoed back on reads
  typedef logic [`TCDM_ID_W-1:0] id_t;

endpackage

`default_nettype wire

// File: design/tcdm_config.svh
// default tcdm sizes as macros, include in any package or module that needs a size
`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

// bank geometry, both powers of two
`define TCDM_NB_BANKS    4
`define TCDM_BANK_WORDS  64

// request fields
`define TCDM_DATA_W      32   // word width in bits
`define TCDM_ADDR_W      16   // byte address
`define TCDM_ID_W        4

// command buffering in front of the port controller
`define TCDM_FIFO_DEPTH  4

`endif
